// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_core_top
FILELIST := filelist.f
LOG      := sim.log
PASS_MSG := test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: filelist.f
hw/core_pkg.sv
hw/game_video_if.sv
hw/core_settings.sv
hw/coin_pulse.sv
hw/input_mapper.sv
hw/video_formatter.sv
hw/dataslot_ctrl.sv
hw/core_top.sv
test/tb_clk_gen.sv
test/tb_core_top.sv

// File: hw/coin_pulse.sv
// coin pulse stretcher
// release of the coin request starts a fixed-length pulse
`timescale 1ns/10ps

module coin_pulse (
   input  logic clk_74a,
   input  logic pll_core_locked,
   input  logic coin_req,
   output logic pulse
);

   logic                            req_d;
   logic                            release_seen;
   logic [core_pkg::coin_cnt_w-1:0] count;

   // falling edge of the request, i.e. the button let go
   assign release_seen = req_d & ~coin_req;

   always_ff @(posedge clk_74a or negedge pll_core_locked) begin
      if (!pll_core_locked) begin
         req_d <= 1'b0;
         count <= '0;
      end else begin
         req_d <= coin_req;
         if (count != '0) begin
            // pulse running, new edges ignored
            count <= count - 1'b1;
         end else if (release_seen) begin
            count <= core_pkg::coin_pulse_cycles[core_pkg::coin_cnt_w-1:0];
         end
      end
   end

   // high for exactly the loaded number of cycles
   assign pulse = (count != '0);

endmodule

// File: hw/core_pkg.sv
// shared constants for the arcade glue layer
// bridge and controller widths, settings addresses, data-slot values
// and the dip switch byte union
package core_pkg;

   ////////////////////////////////////////////////////////////
   // bus and controller widths
   localparam int addr_w      = 32;
   localparam int data_w      = 32;
   localparam int key_w       = 16;
   localparam int sync_stages = 3;

   // coin pulse length in clk_74a cycles
   localparam int coin_pulse_cycles = 64;
   localparam int coin_cnt_w        = $clog2(coin_pulse_cycles + 1);

   // hblank delay in pixel enables
   localparam int hblank_delay = 9;

   ////////////////////////////////////////////////////////////
   // core settings addresses
   localparam logic [addr_w-1:0] addr_players     = 32'h8000_0000;
   localparam logic [addr_w-1:0] addr_first_bonus = 32'h9000_0000;
   localparam logic [addr_w-1:0] addr_next_bonus  = 32'h1000_0000;
   localparam logic [addr_w-1:0] addr_difficulty  = 32'h2000_0000;

   // data-slot table entries
   localparam logic [9:0]        dt_rom_size_addr  = 10'd1;
   localparam logic [9:0]        dt_save_size_addr = 10'd3;
   localparam logic [data_w-1:0] dt_save_size      = 32'd65536;

   ////////////////////////////////////////////////////////////
   // controller key bitmap positions
   localparam int key_up      = 0;
   localparam int key_down    = 1;
   localparam int key_left    = 2;
   localparam int key_right   = 3;
   localparam int key_fire    = 4;
   localparam int key_trig_l1 = 8;
   localparam int key_select  = 14;
   localparam int key_start   = 15;

   // video widths
   localparam int chan_w = 4;
   localparam int rgb_w  = 24;

   // dip switch byte as the game sees it (raw) or by setting (fields)
   // each field is stored bit reversed, so raw bit 7 is players bit 0
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic [1:0] players;
         logic [1:0] next_bonus;
         logic [1:0] first_bonus;
         logic [1:0] difficulty;
      } fields;
   } dip_switch_u;

endpackage

// File: hw/core_settings.sv
// core settings registers
// bridge writes to four addresses, packed into the dip switch byte
`timescale 1ns/10ps

module core_settings (
   input  logic                       clk_74a,
   input  logic                       pll_core_locked,
   input  logic                       bridge_wr,
   input  logic [core_pkg::addr_w-1:0] bridge_addr,
   input  logic [core_pkg::data_w-1:0] bridge_wr_data,
   output core_pkg::dip_switch_u      dip_sw
);

   // setting value as the game wants it, low bit first
   logic [1:0] wr_val_rev;

   assign wr_val_rev = {bridge_wr_data[0], bridge_wr_data[1]};

   ////////////////////////////////////////////////////////////
   // address decode, one field per address
   always_ff @(posedge clk_74a or negedge pll_core_locked) begin
      if (!pll_core_locked) begin
         // all settings default to 0
         dip_sw.raw <= 8'h00;
      end else if (bridge_wr) begin
         case (bridge_addr)
            core_pkg::addr_players: begin
               dip_sw.fields.players <= wr_val_rev;
            end
            core_pkg::addr_first_bonus: begin
               dip_sw.fields.first_bonus <= wr_val_rev;
            end
            core_pkg::addr_next_bonus: begin
               dip_sw.fields.next_bonus <= wr_val_rev;
            end
            core_pkg::addr_difficulty: begin
               dip_sw.fields.difficulty <= wr_val_rev;
            end
            default: begin
               // other addresses belong to other bridge devices
               dip_sw <= dip_sw;
            end
         endcase
      end
   end

endmodule

// File: hw/core_top.sv
// arcade core glue top level
// settings, input mapping, video formatting and data-slot control
// between the platform ports and the game's ports
`timescale 1ns/10ps

module core_top (
   // clock and reset
   input  logic                       clk_74a,
   input  logic                       pll_core_locked,
   // bridge and controllers
   input  logic                       bridge_wr,
   input  logic [core_pkg::addr_w-1:0] bridge_addr,
   input  logic [core_pkg::data_w-1:0] bridge_wr_data,
   input  logic [core_pkg::key_w-1:0]  cont1_key,
   input  logic [core_pkg::key_w-1:0]  cont2_key,
   // game video in
   input  logic [core_pkg::chan_w-1:0] game_r,
   input  logic [core_pkg::chan_w-1:0] game_g,
   input  logic [core_pkg::chan_w-1:0] game_b,
   input  logic                       game_hsync_n,
   input  logic                       game_vsync_n,
   input  logic                       game_hblank,
   input  logic                       game_vblank,
   input  logic                       game_pix,
   // scaler video out
   output logic [core_pkg::rgb_w-1:0]  video_rgb,
   output logic                       video_de,
   output logic                       video_hs,
   output logic                       video_vs,
   // game control out
   output logic [7:0]                 game_sw1,
   output logic [7:0]                 game_sw2,
   output logic [7:0]                 game_dip_sw1,
   output logic                       game_pause,
   // data slot
   input  logic [core_pkg::data_w-1:0] datatable_q,
   output logic [9:0]                 datatable_addr,
   output logic                       datatable_wren,
   output logic [core_pkg::data_w-1:0] datatable_data,
   output logic [core_pkg::data_w-1:0] rom_file_size,
   input  logic                       dataslot_requestwrite,
   input  logic                       dataslot_allcomplete,
   input  logic                       host_reset_n,
   output logic                       game_reset_n
);

   core_pkg::dip_switch_u dip_sw;

   game_video_if game_video ();

   ////////////////////////////////////////////////////////////
   // game video onto the bundle, source side
   assign game_video.r       = game_r;
   assign game_video.g       = game_g;
   assign game_video.b       = game_b;
   assign game_video.hsync_n = game_hsync_n;
   assign game_video.vsync_n = game_vsync_n;
   assign game_video.hblank  = game_hblank;
   assign game_video.vblank  = game_vblank;
   assign game_video.pix     = game_pix;

   ////////////////////////////////////////////////////////////
   // settings
   core_settings core_settings_inst (
      .clk_74a         (clk_74a),
      .pll_core_locked (pll_core_locked),
      .bridge_wr       (bridge_wr),
      .bridge_addr     (bridge_addr),
      .bridge_wr_data  (bridge_wr_data),
      .dip_sw          (dip_sw)
   );

   // game reads the byte as is
   assign game_dip_sw1 = dip_sw.raw;

   // controls
   input_mapper input_mapper_inst (
      .clk_74a         (clk_74a),
      .pll_core_locked (pll_core_locked),
      .cont1_key       (cont1_key),
      .cont2_key       (cont2_key),
      .sw1             (game_sw1),
      .sw2             (game_sw2),
      .pause           (game_pause)
   );

   // video
   video_formatter video_formatter_inst (
      .clk_74a         (clk_74a),
      .pll_core_locked (pll_core_locked),
      .game            (game_video.sink),
      .video_rgb       (video_rgb),
      .video_de        (video_de),
      .video_hs        (video_hs),
      .video_vs        (video_vs)
   );

   // data slots and game reset
   dataslot_ctrl dataslot_ctrl_inst (
      .clk_74a               (clk_74a),
      .pll_core_locked       (pll_core_locked),
      .datatable_q           (datatable_q),
      .datatable_addr        (datatable_addr),
      .datatable_wren        (datatable_wren),
      .datatable_data        (datatable_data),
      .rom_file_size         (rom_file_size),
      .dataslot_requestwrite (dataslot_requestwrite),
      .dataslot_allcomplete  (dataslot_allcomplete),
      .host_reset_n          (host_reset_n),
      .game_reset_n          (game_reset_n)
   );

endmodule

// File: hw/dataslot_ctrl.sv
// data-slot table sequencer and download guard
// writes the save size, reads back the rom size, holds game reset
// while a rom download is running
`timescale 1ns/10ps

module dataslot_ctrl (
   input  logic                       clk_74a,
   input  logic                       pll_core_locked,
   input  logic [core_pkg::data_w-1:0] datatable_q,
   output logic [9:0]                 datatable_addr,
   output logic                       datatable_wren,
   output logic [core_pkg::data_w-1:0] datatable_data,
   output logic [core_pkg::data_w-1:0] rom_file_size,
   input  logic                       dataslot_requestwrite,
   input  logic                       dataslot_allcomplete,
   input  logic                       host_reset_n,
   output logic                       game_reset_n
);

   // free running phase counter
   logic [2:0] div;
   logic       write_phase;
   logic       downloading;

   assign write_phase = (div > 3'd4);

   ////////////////////////////////////////////////////////////
   // table access sequence
   always_ff @(posedge clk_74a or negedge pll_core_locked) begin
      if (!pll_core_locked) begin
         div            <= 3'd0;
         datatable_wren <= 1'b0;
         rom_file_size  <= '0;
      end else begin
         div            <= div + 3'd1;
         // write on phases 5..7, read the rest
         datatable_wren <= write_phase;
         // read data is settled by phase 4
         if (div == 3'd4) begin
            rom_file_size <= datatable_q;
         end
      end
   end

   // address and data follow the phase
   always_ff @(posedge clk_74a) begin
      if (write_phase) begin
         datatable_addr <= core_pkg::dt_save_size_addr;
         datatable_data <= core_pkg::dt_save_size;
      end else begin
         datatable_addr <= core_pkg::dt_rom_size_addr;
      end
   end

   ////////////////////////////////////////////////////////////
   // download guard
   always_ff @(posedge clk_74a or negedge pll_core_locked) begin
      if (!pll_core_locked) begin
         downloading  <= 1'b0;
         game_reset_n <= 1'b0;
      end else begin
         // set has priority over clear
         if (dataslot_requestwrite) begin
            downloading <= 1'b1;
         end else if (dataslot_allcomplete) begin
            downloading <= 1'b0;
         end
         game_reset_n <= host_reset_n & ~downloading;
      end
   end

endmodule

// File: hw/game_video_if.sv
// game video bundle
// colour channels, active-low syncs, blanking and pixel clock level
`timescale 1ns/10ps

interface game_video_if;

   // colour channels straight from the game
   logic [core_pkg::chan_w-1:0] r;
   logic [core_pkg::chan_w-1:0] g;
   logic [core_pkg::chan_w-1:0] b;
   // syncs are active low
   logic hsync_n;
   logic vsync_n;
   logic hblank;
   logic vblank;
   // pixel clock, seen as a level on clk_74a
   logic pix;

   modport source (output r, g, b, hsync_n, vsync_n, hblank, vblank, pix);
   modport sink   (input  r, g, b, hsync_n, vsync_n, hblank, vblank, pix);

endinterface

// File: hw/input_mapper.sv
// controller input mapping
// key synchronisers, coin pulse and the game's active-low switch bytes
`timescale 1ns/10ps

module input_mapper (
   input  logic                      clk_74a,
   input  logic                      pll_core_locked,
   input  logic [core_pkg::key_w-1:0] cont1_key,
   input  logic [core_pkg::key_w-1:0] cont2_key,
   output logic [7:0]                sw1,
   output logic [7:0]                sw2,
   output logic                      pause
);

   // synchroniser chains, stage 0 nearest the input
   logic [core_pkg::sync_stages-1:0][core_pkg::key_w-1:0] c1_sync;
   logic [core_pkg::sync_stages-1:0][core_pkg::key_w-1:0] c2_sync;
   logic [core_pkg::key_w-1:0]                            k1;
   logic [core_pkg::key_w-1:0]                            k2;
   logic                                                  coin_req;
   logic                                                  coin_act;

   ////////////////////////////////////////////////////////////
   // synchronisers
   always_ff @(posedge clk_74a or negedge pll_core_locked) begin
      if (!pll_core_locked) begin
         c1_sync <= '0;
         c2_sync <= '0;
      end else begin
         c1_sync <= {c1_sync[core_pkg::sync_stages-2:0], cont1_key};
         c2_sync <= {c2_sync[core_pkg::sync_stages-2:0], cont2_key};
      end
   end

   assign k1 = c1_sync[core_pkg::sync_stages-1];
   assign k2 = c2_sync[core_pkg::sync_stages-1];

   // either select button inserts a coin
   assign coin_req = k1[core_pkg::key_select] | k2[core_pkg::key_select];

   coin_pulse coin_pulse_inst (
      .clk_74a         (clk_74a),
      .pll_core_locked (pll_core_locked),
      .coin_req        (coin_req),
      .pulse           (coin_act)
   );

   ////////////////////////////////////////////////////////////
   // switch bytes, all active low
   // player 1 plus both start buttons
   assign sw1 = {1'b1,
                 ~k2[core_pkg::key_start], ~k1[core_pkg::key_start],
                 ~k1[core_pkg::key_fire], ~k1[core_pkg::key_down],
                 ~k1[core_pkg::key_up], ~k1[core_pkg::key_left],
                 ~k1[core_pkg::key_right]};

   // player 2 plus coin
   assign sw2 = {2'b11, ~coin_act,
                 ~k2[core_pkg::key_fire], ~k2[core_pkg::key_down],
                 ~k2[core_pkg::key_up], ~k2[core_pkg::key_left],
                 ~k2[core_pkg::key_right]};

   // pause from either L1 trigger
   assign pause = k1[core_pkg::key_trig_l1] | k2[core_pkg::key_trig_l1];

endmodule

// File: hw/video_formatter.sv
// scaler video formatter
// pixel enable from pix edges, hblank delay line, rgb expansion
// and one-cycle sync pulses
`timescale 1ns/10ps

module video_formatter (
   input  logic                      clk_74a,
   input  logic                      pll_core_locked,
   game_video_if.sink                game,
   output logic [core_pkg::rgb_w-1:0] video_rgb,
   output logic                      video_de,
   output logic                      video_hs,
   output logic                      video_vs
);

   logic                             pix_d;
   logic                             pix_en;
   logic [core_pkg::hblank_delay-1:0] hbl_line;
   logic                             hblank_dly;
   logic                             active;
   logic                             hsync_n_d;
   logic                             vsync_n_d;

   ////////////////////////////////////////////////////////////
   // pixel enable
   // rising edge of pix, one clk_74a cycle wide
   assign pix_en = game.pix & ~pix_d;

   // game hblank runs ahead of its pixels
   assign hblank_dly = hbl_line[core_pkg::hblank_delay-1];
   assign active     = ~(hblank_dly | game.vblank);

   always_ff @(posedge clk_74a or negedge pll_core_locked) begin
      if (!pll_core_locked) begin
         pix_d    <= 1'b0;
         hbl_line <= '0;
      end else begin
         pix_d <= game.pix;
         // shift once per pixel
         if (pix_en) begin
            hbl_line <= {hbl_line[core_pkg::hblank_delay-2:0], game.hblank};
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // data enable and syncs
   always_ff @(posedge clk_74a or negedge pll_core_locked) begin
      if (!pll_core_locked) begin
         video_de  <= 1'b0;
         video_hs  <= 1'b0;
         video_vs  <= 1'b0;
         // syncs idle high
         hsync_n_d <= 1'b1;
         vsync_n_d <= 1'b1;
      end else begin
         video_de  <= active;
         // pulse only on the first low cycle of each sync
         video_hs  <= hsync_n_d & ~game.hsync_n;
         video_vs  <= vsync_n_d & ~game.vsync_n;
         hsync_n_d <= game.hsync_n;
         vsync_n_d <= game.vsync_n;
      end
   end

   // 4-bit channels doubled into bytes, held outside active video
   always_ff @(posedge clk_74a) begin
      if (active) begin
         video_rgb <= {{2{game.r}}, {2{game.g}}, {2{game.b}}};
      end
   end

endmodule

// File: test/tb_clk_gen.sv
// testbench clock and reset source
// 4 ns clk_74a, pll_core_locked low for the first 4 cycles
`timescale 1ns/10ps

module tb_clk_gen (
   output logic clk_74a,
   output logic pll_core_locked
);

   // 2 ns half period
   initial begin
      clk_74a = 1'b0;
      forever #2 clk_74a = ~clk_74a;
   end

   // release on the 4th rising edge
   initial begin
      pll_core_locked <= 1'b0;
      repeat (4) @(posedge clk_74a);
      pll_core_locked <= 1'b1;
   end

endmodule

// File: test/tb_core_top.sv
// directed testbench for the arcade glue top level
// reset, settings, controls, coin, video and data-slot tests
// with compare tasks per result type
`timescale 1ns/10ps

module tb_core_top;

   logic                        clk_74a;
   logic                        pll_core_locked;
   logic                        bridge_wr;
   logic [core_pkg::addr_w-1:0] bridge_addr;
   logic [core_pkg::data_w-1:0] bridge_wr_data;
   logic [core_pkg::key_w-1:0]  cont1_key;
   logic [core_pkg::key_w-1:0]  cont2_key;
   logic [core_pkg::chan_w-1:0] game_r;
   logic [core_pkg::chan_w-1:0] game_g;
   logic [core_pkg::chan_w-1:0] game_b;
   logic                        game_hsync_n;
   logic                        game_vsync_n;
   logic                        game_hblank;
   logic                        game_vblank;
   logic                        game_pix;
   logic [core_pkg::rgb_w-1:0]  video_rgb;
   logic                        video_de;
   logic                        video_hs;
   logic                        video_vs;
   logic [7:0]                  game_sw1;
   logic [7:0]                  game_sw2;
   logic [7:0]                  game_dip_sw1;
   logic                        game_pause;
   logic [core_pkg::data_w-1:0] datatable_q;
   logic [9:0]                  datatable_addr;
   logic                        datatable_wren;
   logic [core_pkg::data_w-1:0] datatable_data;
   logic [core_pkg::data_w-1:0] rom_file_size;
   logic                        dataslot_requestwrite;
   logic                        dataslot_allcomplete;
   logic                        host_reset_n;
   logic                        game_reset_n;

   integer     seed;
   int         pix_cnt;
   int         pix_rises;
   logic [31:0] rnd;

   tb_clk_gen tb_clk_gen_inst (
      .clk_74a         (clk_74a),
      .pll_core_locked (pll_core_locked)
   );

   // all ports share their names with the DUT
   core_top core_top_inst (.*);

   ////////////////////////////////////////////////////////////
   // failure reporting and compares
   task automatic abort_run(input string line);
      $display("%s", line);
      $display("test failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
         abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_dip(input string name, input core_pkg::dip_switch_u exp,
                            input core_pkg::dip_switch_u act);
      if (act.raw !== exp.raw)
         abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp.raw, act.raw));
   endtask

   task automatic check_word(input string name, input logic [core_pkg::data_w-1:0] exp,
                             input logic [core_pkg::data_w-1:0] act);
      if (act !== exp)
         abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus helpers
   // one bridge write strobe, result sampled after it lands
   task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
      @(posedge clk_74a);
      bridge_wr      <= 1'b1;
      bridge_addr    <= addr;
      bridge_wr_data <= data;
      @(posedge clk_74a);
      bridge_wr <= 1'b0;
      @(negedge clk_74a);
   endtask

   // one clk cycle, pix flips every 2 cycles
   task automatic step_video();
      @(posedge clk_74a);
      pix_cnt = (pix_cnt + 1) % 2;
      if (pix_cnt == 0) begin
         // rising pix edges, one pixel each
         if (game_pix == 1'b0)
            pix_rises++;
         game_pix <= ~game_pix;
      end
      @(negedge clk_74a);
   endtask

   ////////////////////////////////////////////////////////////
   // tests
   task automatic test_reset();
      int n;
      n = 0;
      @(negedge clk_74a);
      while (pll_core_locked !== 1'b1) begin
         @(negedge clk_74a);
         n++;
         if (n > 20)
            abort_run("reset was never released");
      end
      check_bit("reset video_de", 1'b0, video_de);
      check_bit("reset video_hs", 1'b0, video_hs);
      check_bit("reset video_vs", 1'b0, video_vs);
      check_bit("reset datatable_wren", 1'b0, datatable_wren);
      check_bit("reset game_reset_n", 1'b0, game_reset_n);
      check_byte("reset game_sw1", 8'hff, game_sw1);
      check_byte("reset game_sw2", 8'hff, game_sw2);
      check_byte("reset game_dip_sw1", 8'h00, game_dip_sw1);
   endtask

   task automatic test_settings();
      core_pkg::dip_switch_u exp;
      logic [1:0]            v;
      exp.raw = 8'h00;
      // field bits stored reversed
      rnd = $random(seed);
      v = rnd[1:0];
      exp.fields.players = {v[0], v[1]};
      bridge_write(core_pkg::addr_players, rnd);
      check_dip("settings players", exp, game_dip_sw1);
      rnd = $random(seed);
      v = rnd[1:0];
      exp.fields.first_bonus = {v[0], v[1]};
      bridge_write(core_pkg::addr_first_bonus, rnd);
      check_dip("settings first_bonus", exp, game_dip_sw1);
      rnd = $random(seed);
      v = rnd[1:0];
      exp.fields.next_bonus = {v[0], v[1]};
      bridge_write(core_pkg::addr_next_bonus, rnd);
      check_dip("settings next_bonus", exp, game_dip_sw1);
      rnd = $random(seed);
      v = rnd[1:0];
      exp.fields.difficulty = {v[0], v[1]};
      bridge_write(core_pkg::addr_difficulty, rnd);
      check_dip("settings difficulty", exp, game_dip_sw1);
      // no settings register here
      bridge_write(32'h3000_0000, $random(seed));
      check_dip("settings unrelated", exp, game_dip_sw1);
   endtask

   task automatic test_controls();
      logic [15:0] k1;
      logic [15:0] k2;
      for (int i = 0; i < 4; i++) begin
         rnd = $random(seed);
         k1 = rnd[15:0];
         k2 = rnd[31:16];
         // keep select out, a release would fire a coin
         k1[core_pkg::key_select] = 1'b0;
         k2[core_pkg::key_select] = 1'b0;
         @(posedge clk_74a);
         cont1_key <= k1;
         cont2_key <= k2;
         repeat (4) @(posedge clk_74a);
         @(negedge clk_74a);
         check_byte("controls sw1", {1'b1, ~k2[15], ~k1[15], ~k1[4], ~k1[1], ~k1[0], ~k1[2],
                                     ~k1[3]}, game_sw1);
         check_byte("controls sw2", {3'b111, ~k2[4], ~k2[1], ~k2[0], ~k2[2], ~k2[3]}, game_sw2);
         check_bit("controls pause", k1[8] | k2[8], game_pause);
      end
      @(posedge clk_74a);
      cont1_key <= '0;
      cont2_key <= '0;
   endtask

   task automatic test_coin();
      int n;
      int low;
      @(posedge clk_74a);
      cont1_key <= 16'h4000;
      repeat (5) @(posedge clk_74a);
      cont1_key <= '0;
      n = 0;
      @(negedge clk_74a);
      while (game_sw2[5] !== 1'b0) begin
         @(negedge clk_74a);
         n++;
         if (n > 20)
            abort_run("coin bit never went low after select release");
      end
      // count low cycles, including this one
      low = 0;
      while (game_sw2[5] === 1'b0) begin
         low++;
         @(negedge clk_74a);
         if (low > 2 * core_pkg::coin_pulse_cycles)
            abort_run("coin bit stuck low");
      end
      check_word("coin pulse length", core_pkg::coin_pulse_cycles, low);
      check_bit("coin bit after pulse", 1'b1, game_sw2[5]);
   endtask

   task automatic test_video();
      int n;
      int hs_seen;
      int vs_seen;
      logic [core_pkg::rgb_w-1:0] exp_rgb;
      hs_seen = 0;
      vs_seen = 0;
      rnd = $random(seed);
      @(posedge clk_74a);
      game_r       <= rnd[3:0];
      game_g       <= rnd[7:4];
      game_b       <= rnd[11:8];
      game_hsync_n <= 1'b0;
      game_vsync_n <= 1'b0;
      for (int i = 0; i < 10; i++) begin
         step_video();
         if (video_hs === 1'b1)
            hs_seen++;
         if (video_vs === 1'b1)
            vs_seen++;
      end
      check_word("video hs pulses", 1, hs_seen);
      check_word("video vs pulses", 1, vs_seen);
      // fill the hblank delay line while still blanked
      for (int i = 0; i < 4 * core_pkg::hblank_delay; i++) begin
         step_video();
      end
      @(posedge clk_74a);
      game_hsync_n <= 1'b1;
      game_vsync_n <= 1'b1;
      game_hblank  <= 1'b0;
      game_vblank  <= 1'b0;
      pix_rises = 0;
      @(negedge clk_74a);
      // hblank has to clear the whole delay line
      n = 0;
      while (video_de !== 1'b1) begin
         step_video();
         n++;
         if (n > 4 * (core_pkg::hblank_delay + 3))
            abort_run("video_de never went high in active video");
      end
      check_word("video de after hblank delay", core_pkg::hblank_delay, pix_rises);
      exp_rgb = {rnd[3:0], rnd[3:0], rnd[7:4], rnd[7:4], rnd[11:8], rnd[11:8]};
      check_word("video rgb", {8'h00, exp_rgb}, {8'h00, video_rgb});
      @(posedge clk_74a);
      game_vblank <= 1'b1;
      // registered one cycle after vblank rises
      repeat (2) @(negedge clk_74a);
      check_bit("video de in vblank", 1'b0, video_de);
   endtask

   task automatic test_dataslot();
      int n;
      int writes;
      rnd = $random(seed);
      writes = 0;
      @(posedge clk_74a);
      datatable_q <= rnd;
      // new read value in place before the window opens
      @(posedge clk_74a);
      for (int i = 0; i < 8; i++) begin
         @(negedge clk_74a);
         if (datatable_wren === 1'b1) begin
            writes++;
            check_word("dataslot addr", 32'd3, {22'd0, datatable_addr});
            check_word("dataslot data", 32'd65536, datatable_data);
         end else begin
            check_word("dataslot read addr", 32'd1, {22'd0, datatable_addr});
         end
      end
      check_word("dataslot write count", 3, writes);
      check_word("dataslot rom size", rnd, rom_file_size);
      check_bit("dataslot reset idle", 1'b1, game_reset_n);
      @(posedge clk_74a);
      dataslot_requestwrite <= 1'b1;
      @(posedge clk_74a);
      dataslot_requestwrite <= 1'b0;
      n = 0;
      @(negedge clk_74a);
      while (game_reset_n !== 1'b0) begin
         @(negedge clk_74a);
         n++;
         if (n > 8)
            abort_run("game reset not asserted during download");
      end
      @(posedge clk_74a);
      dataslot_allcomplete <= 1'b1;
      @(posedge clk_74a);
      dataslot_allcomplete <= 1'b0;
      n = 0;
      @(negedge clk_74a);
      while (game_reset_n !== 1'b1) begin
         @(negedge clk_74a);
         n++;
         if (n > 8)
            abort_run("game reset not released after download");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // sequence
   initial begin
      seed       = 83;
      pix_cnt    = 0;
      pix_rises  = 0;
      bridge_wr             <= 1'b0;
      bridge_addr           <= '0;
      bridge_wr_data        <= '0;
      cont1_key             <= '0;
      cont2_key             <= '0;
      game_r                <= '0;
      game_g                <= '0;
      game_b                <= '0;
      // syncs idle high, start blanked
      game_hsync_n          <= 1'b1;
      game_vsync_n          <= 1'b1;
      game_hblank           <= 1'b1;
      game_vblank           <= 1'b1;
      game_pix              <= 1'b0;
      datatable_q           <= '0;
      dataslot_requestwrite <= 1'b0;
      dataslot_allcomplete  <= 1'b0;
      host_reset_n          <= 1'b1;
      test_reset();
      test_settings();
      test_controls();
      test_coin();
      test_video();
      test_dataslot();
      $display("test passed");
      $finish;
   end

endmodule
